/* sys_reg.f */
+incdir+sim
hw/sys_reg_pkg.sv
hw/axil_write_stage.sv
hw/axil_read_stage.sv
hw/sys_reg_bank.sv
hw/sys_reg.sv
sim/tb_sys_reg.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the SRIO register block testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_sys_reg \
  -f sys_reg.f -o sim_sys_reg \
  && ./obj_dir/sim_sys_reg | tee sim.log \
  || { echo "Build or simulation error"; exit 1; }
grep -q "test failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "test passed" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation finished without failures"

/* sim/tb_sys_reg_model.svh */
// SRIO register block testbench support
// Register model, AXI4-Lite driver tasks, value check and run watchdog
`ifndef TB_SYS_REG_MODEL_SVH
`define TB_SYS_REG_MODEL_SVH

// Model copies of register 0 and register 2
logic [31:0] ctrl_m;
logic [31:0] dest_m;
int          err_count;
int          cycle_count;

// Only strobed bytes take new data in a write
function automatic logic [31:0] strobe_update(
  input logic [31:0] old_w,
  input logic [31:0] new_w,
  input logic [3:0]  strb
);
  logic [31:0] w;
  w = old_w;
  for (int b = 0; b < 4; b++)
  begin
    if (strb[b])
    begin
      w[8*b +: 8] = new_w[8*b +: 8];
    end
  end
  return w;
endfunction

// Status layout with device ID on top and transceiver flags at the bottom
function automatic logic [31:0] expected_status();
  return {device_id, 6'b000000, phy_rcvd_link_reset, phy_rcvd_mce, 1'b0,
          gtrx_disperr_or, gtrx_notintable_or, port_error, srio_mode_1x,
          srio_clk_out_lock, srio_port_initialized, srio_link_initialized};
endfunction

function automatic logic [31:0] expected_read(input logic [2:0] idx);
  logic [31:0] w;
  case (idx)
    3'd0:    w = ctrl_m;
    3'd1:    w = expected_status();
    3'd2:    w = dest_m;
    default: w = 32'd0;
  endcase
  return w;
endfunction

// Writes to index 1 and 3 to 7 leave the model alone
task automatic model_write(input logic [2:0] idx, input logic [31:0] data,
                           input logic [3:0] strb);
  if (idx == 3'd0)
  begin
    ctrl_m = strobe_update(ctrl_m, data, strb);
  end
  else if (idx == 3'd2)
  begin
    dest_m = strobe_update(dest_m, data, strb);
  end
endtask

task automatic check_value(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
  if (exp_v !== act_v)
  begin
    err_count++;
    $display("ERR %s expected %h actual %h", name, exp_v, act_v);
  end
endtask

// SRIO outputs against the control layout with per lane fields copied four times
task automatic check_srio(input string name);
  check_value({name, " core"},
              32'({ctrl_m[0], ctrl_m[1], ctrl_m[23:21], ctrl_m[8:5]}),
              32'({srio_reset, swrite_bypass, phy_mce, force_reinit,
                   phy_link_reset, gt_diffctrl}));
  check_value({name, " loopback"}, 32'({4{ctrl_m[4:2]}}), 32'(srio_loopback));
  check_value({name, " txpre"}, 32'({4{ctrl_m[13:9]}}), 32'(gt_txprecursor));
  check_value({name, " txpost"}, 32'({4{ctrl_m[18:14]}}), 32'(gt_txpostcursor));
  check_value({name, " lpm"}, 32'({{4{ctrl_m[20]}}, {4{ctrl_m[19]}}}),
              32'({gt_rxdfelpmreset, gt_rxlpmen}));
  check_value({name, " adc"}, 32'(dest_m[1:0]), 32'({adc_sw_dest1, adc_sw_dest0}));
endtask

//////////////////////////////////////////////////////////////////////
// AXI4-Lite master side driving on the falling edge

task automatic present_aw(input logic [2:0] idx, input logic [31:0] data,
                          input logic [3:0] strb);
  s_axi_awaddr  = {idx, 2'b00};
  s_axi_wdata   = data;
  s_axi_wstrb   = strb;
  s_axi_awvalid = 1'b1;
  s_axi_wvalid  = 1'b1;
endtask

// Ready seen on a falling edge means the handshake closes at the next rising edge
task automatic finish_aw();
  do
  begin
    @(negedge S_AXI_ACLK);
  end
  while (!s_axi_awready);
  // Both ready lines rise together
  check_value("wready with awready", 32'd1, 32'(s_axi_wready));
  @(negedge S_AXI_ACLK);
  // Ready pulse lasts a single cycle
  check_value("ready pulse width", 32'd0, 32'({s_axi_awready, s_axi_wready}));
  s_axi_awvalid = 1'b0;
  s_axi_wvalid  = 1'b0;
endtask

task automatic take_b(input string name);
  while (!s_axi_bvalid)
  begin
    @(negedge S_AXI_ACLK);
  end
  check_value({name, " bresp"}, 32'd0, 32'(s_axi_bresp));
  s_axi_bready = 1'b1;
  @(negedge S_AXI_ACLK);
  s_axi_bready = 1'b0;
endtask

task automatic write_reg(input string name, input logic [2:0] idx,
                         input logic [31:0] data, input logic [3:0] strb);
  present_aw(idx, data, strb);
  finish_aw();
  model_write(idx, data, strb);
  take_b(name);
endtask

task automatic send_ar(input logic [2:0] idx);
  s_axi_araddr  = {idx, 2'b00};
  s_axi_arvalid = 1'b1;
  do
  begin
    @(negedge S_AXI_ACLK);
  end
  while (!s_axi_arready);
  @(negedge S_AXI_ACLK);
  s_axi_arvalid = 1'b0;
endtask

task automatic take_r(input string name, output logic [31:0] data);
  while (!s_axi_rvalid)
  begin
    @(negedge S_AXI_ACLK);
  end
  data = s_axi_rdata;
  check_value({name, " rresp"}, 32'd0, 32'(s_axi_rresp));
  s_axi_rready = 1'b1;
  @(negedge S_AXI_ACLK);
  s_axi_rready = 1'b0;
endtask

task automatic read_check(input string name, input logic [2:0] idx);
  logic [31:0] data;
  send_ar(idx);
  take_r(name, data);
  check_value(name, expected_read(idx), data);
endtask

// Cycle budget from the transaction count stops a stuck handshake
initial
begin : watchdog
  cycle_count = 0;
  while (cycle_count < TIMEOUT_CYCLES)
  begin
    @(posedge S_AXI_ACLK);
    cycle_count++;
  end
  $display("Timeout: a handshake never completed within %0d cycles", cycle_count);
  $display("test failed");
  $finish;
end

`endif

/* sim/tb_sys_reg.sv */
// SRIO register block testbench
// Random register traffic, status readback and back-pressure against a model
`timescale 1ns/1ps

module tb_sys_reg;

  localparam int NUM_RANDOM = 100;
  localparam int NUM_STATUS = 8;
  // Reset reads, write and read per random pass, status reads, back-pressure
  localparam int NUM_TRANS      = 2 + 2 * NUM_RANDOM + NUM_STATUS + 4;
  localparam int TIMEOUT_CYCLES = 200 * NUM_TRANS;

  logic        S_AXI_ACLK;
  logic        S_AXI_ARESETN;
  logic [4:0]  s_axi_awaddr;
  logic        s_axi_awvalid;
  logic        s_axi_awready;
  logic [31:0] s_axi_wdata;
  logic [3:0]  s_axi_wstrb;
  logic        s_axi_wvalid;
  logic        s_axi_wready;
  logic [1:0]  s_axi_bresp;
  logic        s_axi_bvalid;
  logic        s_axi_bready;
  logic [4:0]  s_axi_araddr;
  logic        s_axi_arvalid;
  logic        s_axi_arready;
  logic [31:0] s_axi_rdata;
  logic [1:0]  s_axi_rresp;
  logic        s_axi_rvalid;
  logic        s_axi_rready;
  logic        srio_reset;
  logic        swrite_bypass;
  logic [11:0] srio_loopback;
  logic [3:0]  gt_diffctrl;
  logic [19:0] gt_txprecursor;
  logic [19:0] gt_txpostcursor;
  logic [3:0]  gt_rxlpmen;
  logic [3:0]  gt_rxdfelpmreset;
  logic        phy_link_reset;
  logic        force_reinit;
  logic        phy_mce;
  logic        adc_sw_dest0;
  logic        adc_sw_dest1;
  logic        srio_mode_1x;
  logic        srio_clk_out_lock;
  logic        srio_port_initialized;
  logic        srio_link_initialized;
  logic        gtrx_disperr_or;
  logic        gtrx_notintable_or;
  logic        port_error;
  logic        phy_rcvd_link_reset;
  logic        phy_rcvd_mce;
  logic [15:0] device_id;

  int tests_run;
  int tests_failed;
  int err_at_start;

  `include "tb_sys_reg_model.svh"

  sys_reg #(
    .ADDR_WIDTH (5)
  ) DUT (.*);

  always #20 S_AXI_ACLK = ~S_AXI_ACLK;

  //////////////////////////////////////////////////////////////////////
  // Test bookkeeping

  task automatic end_test(input string name);
    tests_run++;
    if (err_count == err_at_start)
    begin
      $display("[%s] ok", name);
    end
    else
    begin
      tests_failed++;
      $display("[%s] %0d mismatches", name, err_count - err_at_start);
    end
    err_at_start = err_count;
  endtask

  // New random transceiver status applied on the falling edge
  task automatic randomize_status();
    logic [31:0] rnd;
    rnd = $urandom();
    device_id             = rnd[31:16];
    srio_mode_1x          = rnd[0];
    srio_clk_out_lock     = rnd[1];
    srio_port_initialized = rnd[2];
    srio_link_initialized = rnd[3];
    gtrx_disperr_or       = rnd[4];
    gtrx_notintable_or    = rnd[5];
    port_error            = rnd[6];
    phy_rcvd_link_reset   = rnd[7];
    phy_rcvd_mce          = rnd[8];
  endtask

  initial
  begin : main
    logic [31:0] rnd;
    logic [31:0] data;
    logic [31:0] held;
    logic [2:0]  idx;
    int          hold;
    void'($urandom(31));
    S_AXI_ACLK    = 1'b0;
    S_AXI_ARESETN = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    device_id     = '0;
    {srio_mode_1x, srio_clk_out_lock, srio_port_initialized, srio_link_initialized} = '0;
    {gtrx_disperr_or, gtrx_notintable_or, port_error} = '0;
    {phy_rcvd_link_reset, phy_rcvd_mce} = '0;
    ctrl_m       = '0;
    dest_m       = '0;
    err_count    = 0;
    err_at_start = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (16) @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
    @(negedge S_AXI_ACLK);

    // Everything comes out of reset cleared
    check_srio("reset");
    read_check("reset read ctrl", 3'd0);
    read_check("reset read dest", 3'd2);
    end_test("reset_values");

    // Strobed writes across the whole index range, each read back
    randomize_status();
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      rnd  = $urandom();
      idx  = rnd[2:0];
      data = $urandom();
      write_reg($sformatf("write %0d idx %0d", i, idx), idx, data, rnd[7:4]);
      check_srio($sformatf("srio after write %0d", i));
      read_check($sformatf("read %0d idx %0d", i, idx), idx);
    end
    end_test("random_access");

    for (int i = 0; i < NUM_STATUS; i++)
    begin
      randomize_status();
      read_check($sformatf("status %0d", i), 3'd1);
    end
    end_test("status_word");

    // Write response stalled with a second write waiting behind it
    hold = $urandom_range(10, 1);
    data = $urandom();
    present_aw(3'd0, data, 4'hf);
    finish_aw();
    model_write(3'd0, data, 4'hf);
    rnd = $urandom();
    present_aw(3'd2, rnd, 4'h1);
    for (int k = 0; k < hold; k++)
    begin
      @(negedge S_AXI_ACLK);
      check_value("bp bvalid held", 32'd1, 32'(s_axi_bvalid));
      check_value("bp awready low", 32'd0, 32'(s_axi_awready));
    end
    take_b("bp first write");
    finish_aw();
    model_write(3'd2, rnd, 4'h1);
    take_b("bp second write");
    check_srio("bp srio");

    // Read data must not move while RREADY stays low
    hold = $urandom_range(10, 1);
    send_ar(3'd2);
    held = expected_read(3'd2);
    for (int k = 0; k < hold; k++)
    begin
      @(negedge S_AXI_ACLK);
      check_value("bp rvalid held", 32'd1, 32'(s_axi_rvalid));
      check_value("bp rdata held", held, s_axi_rdata);
    end
    take_r("bp read dest", data);
    check_value("bp read dest", expected_read(3'd2), data);
    read_check("bp read ctrl", 3'd0);
    end_test("back_pressure");

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* hw/sys_reg.sv */
// SRIO system register block top level
// AXI4-Lite slave with write and read stages in front of the bank
`timescale 1ns/1ps

module sys_reg #(
  parameter int ADDR_WIDTH = 5
) (
  input  logic                                 S_AXI_ACLK,
  input  logic                                 S_AXI_ARESETN,
  // AXI4-Lite write channels
  input  logic [ADDR_WIDTH-1:0]                s_axi_awaddr,
  input  logic                                 s_axi_awvalid,
  output logic                                 s_axi_awready,
  input  sys_reg_pkg::reg_word_t               s_axi_wdata,
  input  logic [sys_reg_pkg::STRB_WIDTH-1:0]   s_axi_wstrb,
  input  logic                                 s_axi_wvalid,
  output logic                                 s_axi_wready,
  output logic [1:0]                           s_axi_bresp,
  output logic                                 s_axi_bvalid,
  input  logic                                 s_axi_bready,
  // AXI4-Lite read channels
  input  logic [ADDR_WIDTH-1:0]                s_axi_araddr,
  input  logic                                 s_axi_arvalid,
  output logic                                 s_axi_arready,
  output sys_reg_pkg::reg_word_t               s_axi_rdata,
  output logic [1:0]                           s_axi_rresp,
  output logic                                 s_axi_rvalid,
  input  logic                                 s_axi_rready,
  // SRIO control
  output logic                                 srio_reset,
  output logic                                 swrite_bypass,
  output logic [3*sys_reg_pkg::NUM_LANES-1:0]  srio_loopback,
  output logic [3:0]                           gt_diffctrl,
  output logic [5*sys_reg_pkg::NUM_LANES-1:0]  gt_txprecursor,
  output logic [5*sys_reg_pkg::NUM_LANES-1:0]  gt_txpostcursor,
  output logic [sys_reg_pkg::NUM_LANES-1:0]    gt_rxlpmen,
  output logic [sys_reg_pkg::NUM_LANES-1:0]    gt_rxdfelpmreset,
  output logic                                 phy_link_reset,
  output logic                                 force_reinit,
  output logic                                 phy_mce,
  // ADC sink destination
  output logic                                 adc_sw_dest0,
  output logic                                 adc_sw_dest1,
  // Transceiver status
  input  logic                                 srio_mode_1x,
  input  logic                                 srio_clk_out_lock,
  input  logic                                 srio_port_initialized,
  input  logic                                 srio_link_initialized,
  input  logic                                 gtrx_disperr_or,
  input  logic                                 gtrx_notintable_or,
  input  logic                                 port_error,
  input  logic                                 phy_rcvd_link_reset,
  input  logic                                 phy_rcvd_mce,
  input  logic [15:0]                          device_id
);

  sys_reg_pkg::wr_req_t                     wr_req;
  logic                                     wr_en;
  logic [sys_reg_pkg::REG_INDEX_WIDTH-1:0]  rd_index;
  sys_reg_pkg::reg_word_t                   rd_data;
  sys_reg_pkg::srio_status_t                status;

  //////////////////////////////////////////////////////////////////////
  // Status word, unused bits read as zero

  always_comb
  begin
    status                       = '0;
    status.device_id             = device_id;
    status.phy_rcvd_link_reset   = phy_rcvd_link_reset;
    status.phy_rcvd_mce          = phy_rcvd_mce;
    status.gtrx_disperr_or       = gtrx_disperr_or;
    status.gtrx_notintable_or    = gtrx_notintable_or;
    status.port_error            = port_error;
    status.srio_mode_1x          = srio_mode_1x;
    status.srio_clk_out_lock     = srio_clk_out_lock;
    status.srio_port_initialized = srio_port_initialized;
    status.srio_link_initialized = srio_link_initialized;
  end

  //////////////////////////////////////////////////////////////////////
  // Channel stages and bank

  axil_write_stage #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_write (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .wr_req        (wr_req),
    .wr_en         (wr_en)
  );

  axil_read_stage #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_read (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .rd_index      (rd_index),
    .rd_data       (rd_data)
  );

  sys_reg_bank u_bank (
    .S_AXI_ACLK       (S_AXI_ACLK),
    .S_AXI_ARESETN    (S_AXI_ARESETN),
    .wr_req           (wr_req),
    .wr_en            (wr_en),
    .rd_index         (rd_index),
    .rd_data          (rd_data),
    .status           (status),
    .srio_reset       (srio_reset),
    .swrite_bypass    (swrite_bypass),
    .srio_loopback    (srio_loopback),
    .gt_diffctrl      (gt_diffctrl),
    .gt_txprecursor   (gt_txprecursor),
    .gt_txpostcursor  (gt_txpostcursor),
    .gt_rxlpmen       (gt_rxlpmen),
    .gt_rxdfelpmreset (gt_rxdfelpmreset),
    .phy_link_reset   (phy_link_reset),
    .force_reinit     (force_reinit),
    .phy_mce          (phy_mce),
    .adc_sw_dest0     (adc_sw_dest0),
    .adc_sw_dest1     (adc_sw_dest1)
  );

endmodule

/* hw/sys_reg_bank.sv */
// SRIO register bank
// Control and destination registers, status readback and SRIO drive
`timescale 1ns/1ps

module sys_reg_bank (
  input  logic                                     S_AXI_ACLK,
  input  logic                                     S_AXI_ARESETN,
  input  sys_reg_pkg::wr_req_t                     wr_req,
  input  logic                                     wr_en,
  input  logic [sys_reg_pkg::REG_INDEX_WIDTH-1:0]  rd_index,
  output sys_reg_pkg::reg_word_t                   rd_data,
  input  sys_reg_pkg::srio_status_t                status,
  output logic                                     srio_reset,
  output logic                                     swrite_bypass,
  output logic [3*sys_reg_pkg::NUM_LANES-1:0]      srio_loopback,
  output logic [3:0]                               gt_diffctrl,
  output logic [5*sys_reg_pkg::NUM_LANES-1:0]      gt_txprecursor,
  output logic [5*sys_reg_pkg::NUM_LANES-1:0]      gt_txpostcursor,
  output logic [sys_reg_pkg::NUM_LANES-1:0]        gt_rxlpmen,
  output logic [sys_reg_pkg::NUM_LANES-1:0]        gt_rxdfelpmreset,
  output logic                                     phy_link_reset,
  output logic                                     force_reinit,
  output logic                                     phy_mce,
  output logic                                     adc_sw_dest0,
  output logic                                     adc_sw_dest1
);

  // Register 0, SRIO control
  sys_reg_pkg::reg_word_t ctrl_q;
  // Register 2, ADC sink select
  sys_reg_pkg::reg_word_t dest_q;
  // Field view of register 0
  sys_reg_pkg::srio_ctrl_t ctrl_f;

  // Replace only the strobed bytes of a word
  function automatic sys_reg_pkg::reg_word_t merge_bytes(
    input sys_reg_pkg::reg_word_t                old_word,
    input sys_reg_pkg::reg_word_t                new_word,
    input logic [sys_reg_pkg::STRB_WIDTH-1:0]    strb
  );
    sys_reg_pkg::reg_word_t result;
    result = old_word;
    for (int b = 0; b < sys_reg_pkg::STRB_WIDTH; b++)
    begin
      if (strb[b])
      begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Register write

  // Status is read only, indices 3 to 7 have no storage
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      ctrl_q <= '0;
      dest_q <= '0;
    end
    else if (wr_en)
    begin
      case (wr_req.index)
        sys_reg_pkg::REG_CTRL:
        begin
          ctrl_q <= merge_bytes(ctrl_q, wr_req.data, wr_req.strb);
        end
        sys_reg_pkg::REG_DEST:
        begin
          dest_q <= merge_bytes(dest_q, wr_req.data, wr_req.strb);
        end
        default:
        begin
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux

  always_comb
  begin
    case (rd_index)
      sys_reg_pkg::REG_CTRL:   rd_data = ctrl_q;
      sys_reg_pkg::REG_STATUS: rd_data = status;
      sys_reg_pkg::REG_DEST:   rd_data = dest_q;
      default:                 rd_data = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // SRIO control decode

  assign ctrl_f = ctrl_q;

  // Core level controls
  assign srio_reset     = ctrl_f.srio_reset;
  assign swrite_bypass  = ctrl_f.swrite_bypass;
  assign phy_link_reset = ctrl_f.phy_link_reset;
  assign force_reinit   = ctrl_f.force_reinit;
  assign phy_mce        = ctrl_f.phy_mce;

  // Single diffctrl bus shared by the quad
  assign gt_diffctrl = ctrl_f.diffctrl;

  // Per lane settings, every lane gets the same value
  assign srio_loopback    = {sys_reg_pkg::NUM_LANES{ctrl_f.loopback}};
  assign gt_txprecursor   = {sys_reg_pkg::NUM_LANES{ctrl_f.txprecursor}};
  assign gt_txpostcursor  = {sys_reg_pkg::NUM_LANES{ctrl_f.txpostcursor}};
  assign gt_rxlpmen       = {sys_reg_pkg::NUM_LANES{ctrl_f.rxlpmen}};
  assign gt_rxdfelpmreset = {sys_reg_pkg::NUM_LANES{ctrl_f.rxdfelpmreset}};

  // ADC data sink, DDR or SRIO
  assign adc_sw_dest0 = dest_q[0];
  assign adc_sw_dest1 = dest_q[1];

endmodule

/* hw/axil_read_stage.sv */
// AXI4-Lite read channel front end
// Latches the read index and returns the bank word one cycle later
`timescale 1ns/1ps

module axil_read_stage #(
  parameter int ADDR_WIDTH = 5
) (
  input  logic                                     S_AXI_ACLK,
  input  logic                                     S_AXI_ARESETN,
  input  logic [ADDR_WIDTH-1:0]                    s_axi_araddr,
  input  logic                                     s_axi_arvalid,
  output logic                                     s_axi_arready,
  output sys_reg_pkg::reg_word_t                   s_axi_rdata,
  output logic [1:0]                               s_axi_rresp,
  output logic                                     s_axi_rvalid,
  input  logic                                     s_axi_rready,
  output logic [sys_reg_pkg::REG_INDEX_WIDTH-1:0]  rd_index,
  input  sys_reg_pkg::reg_word_t                   rd_data
);

  // New address only when no read data is waiting
  logic accept;
  // Address handshake completes this cycle
  logic ar_done;

  assign accept  = !s_axi_arready && s_axi_arvalid && !s_axi_rvalid;
  assign ar_done = s_axi_arready && s_axi_arvalid;

  //////////////////////////////////////////////////////////////////////
  // Address channel

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      s_axi_arready <= 1'b0;
      rd_index      <= '0;
    end
    else
    begin
      s_axi_arready <= accept;
      // Index held through the ready cycle so the bank mux settles
      if (accept)
      begin
        rd_index <= s_axi_araddr[sys_reg_pkg::ADDR_LSB +: sys_reg_pkg::REG_INDEX_WIDTH];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data channel

  // Word as seen during the ready cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (ar_done)
    begin
      s_axi_rdata <= rd_data;
    end
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      s_axi_rvalid <= 1'b0;
    end
    else if (ar_done)
    begin
      s_axi_rvalid <= 1'b1;
    end
    else if (s_axi_rready)
    begin
      s_axi_rvalid <= 1'b0;
    end
  end

  assign s_axi_rresp = sys_reg_pkg::RESP_OKAY;

endmodule

/* hw/axil_write_stage.sv */
// AXI4-Lite write channel front end
// Takes address and data together, issues one bank write, returns OKAY
`timescale 1ns/1ps

module axil_write_stage #(
  parameter int ADDR_WIDTH = 5
) (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  logic [ADDR_WIDTH-1:0]               s_axi_awaddr,
  input  logic                                s_axi_awvalid,
  output logic                                s_axi_awready,
  input  sys_reg_pkg::reg_word_t              s_axi_wdata,
  input  logic [sys_reg_pkg::STRB_WIDTH-1:0]  s_axi_wstrb,
  input  logic                                s_axi_wvalid,
  output logic                                s_axi_wready,
  output logic [1:0]                          s_axi_bresp,
  output logic                                s_axi_bvalid,
  input  logic                                s_axi_bready,
  output sys_reg_pkg::wr_req_t                wr_req,
  output logic                                wr_en
);

  // Address and data both present, nothing in flight, no response waiting
  logic accept;

  assign accept = !s_axi_awready && s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;

  //////////////////////////////////////////////////////////////////////
  // Ready generation

  // AW and W ready rise together for a single cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
    end
    else
    begin
      s_axi_awready <= accept;
      s_axi_wready  <= accept;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request capture

  // Master holds the beat until the handshake, so latch it on accept
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept)
    begin
      wr_req.index <= s_axi_awaddr[sys_reg_pkg::ADDR_LSB +: sys_reg_pkg::REG_INDEX_WIDTH];
      wr_req.data  <= s_axi_wdata;
      wr_req.strb  <= s_axi_wstrb;
    end
  end

  // Handshake cycle on both channels applies the write
  assign wr_en = s_axi_awready && s_axi_awvalid && s_axi_wready && s_axi_wvalid;

  //////////////////////////////////////////////////////////////////////
  // Write response

  // Raised the edge after the bank update, held until the master takes it
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      s_axi_bvalid <= 1'b0;
    end
    else if (wr_en)
    begin
      s_axi_bvalid <= 1'b1;
    end
    else if (s_axi_bready)
    begin
      s_axi_bvalid <= 1'b0;
    end
  end

  // No slave errors exist in this map
  assign s_axi_bresp = sys_reg_pkg::RESP_OKAY;

endmodule

/* hw/sys_reg_pkg.sv */
// SRIO system register package
// Shared widths, register map, field layouts and request structs
package sys_reg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths

  // AXI data word, fixed since the field layouts assume 32 bits
  localparam int DATA_WIDTH = 32;
  // One strobe per byte lane
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  // Byte offset bits dropped from the address
  localparam int ADDR_LSB = 2;
  // Word index covers eight slots, only three are populated
  localparam int REG_INDEX_WIDTH = 3;

  //////////////////////////////////////////////////////////////////////
  // Register map

  localparam logic [REG_INDEX_WIDTH-1:0] REG_CTRL   = 3'd0;
  localparam logic [REG_INDEX_WIDTH-1:0] REG_STATUS = 3'd1;
  localparam logic [REG_INDEX_WIDTH-1:0] REG_DEST   = 3'd2;

  // Transceiver lanes fed from one control field
  localparam int NUM_LANES = 4;

  // Only response this block ever returns
  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef logic [DATA_WIDTH-1:0] reg_word_t;

  // One write as handed from the write stage to the bank
  typedef struct packed {
    logic [REG_INDEX_WIDTH-1:0] index;
    reg_word_t                  data;
    logic [STRB_WIDTH-1:0]      strb;
  } wr_req_t;

  // Control register layout, declared from the top bit down
  typedef struct packed {
    logic [7:0] spare;
    logic       phy_mce;
    logic       force_reinit;
    logic       phy_link_reset;
    logic       rxdfelpmreset;
    logic       rxlpmen;
    logic [4:0] txpostcursor;
    logic [4:0] txprecursor;
    logic [3:0] diffctrl;
    logic [2:0] loopback;
    logic       swrite_bypass;
    logic       srio_reset;
  } srio_ctrl_t;

  // Status word layout, top bit first
  typedef struct packed {
    logic [15:0] device_id;
    logic [5:0]  zero_hi;
    logic        phy_rcvd_link_reset;
    logic        phy_rcvd_mce;
    logic        zero_lo;
    logic        gtrx_disperr_or;
    logic        gtrx_notintable_or;
    logic        port_error;
    logic        srio_mode_1x;
    logic        srio_clk_out_lock;
    logic        srio_port_initialized;
    logic        srio_link_initialized;
  } srio_status_t;

endpackage
